//--- rtl/board_cfg_pkg.sv
`default_nettype none

package board_cfg_pkg;

    // status word from the OSD menu
    localparam int STATUS_W   = 32;
    localparam int CORE_MOD_W = 7;

    // single-bit settings inside status
    localparam int ST_ROT_CTRL  = 2;  // rotate controls with the screen
    localparam int ST_NO_ROTATE = 3;
    localparam int ST_FLIP      = 4;
    localparam int ST_TEST      = 5;
    localparam int ST_NO_FM     = 6;
    localparam int ST_NO_PSG    = 7;

    localparam int ST_FXLEVEL_LSB = 8; // 2-bit field

    // core_mod bits
    localparam int CORE_VERTICAL = 0;

    // game reset stretch
    localparam int                    RST_CNT_W     = 8;
    localparam logic [RST_CNT_W-1:0]  GAME_RST_HOLD = 8'd255;

endpackage

`default_nettype wire

//--- rtl/player_io_pkg.sv
`default_nettype none

package player_io_pkg;

    localparam int BOARD_JOY_W = 16; // raw word from the board
    localparam int GAME_JOY_W  = 10; // what the game core sees
    localparam int PLAYERS     = 4;
    localparam int GFX_LAYERS  = 4;

    // game side expects low-true controls
    localparam logic ACTIVE_LOW_INPUTS = 1'b1;

    typedef logic [GAME_JOY_W-1:0] game_joy_t;
    typedef logic [PLAYERS-1:0]    player_bits_t; // bit n is player n+1

    // direction bits in a joystick word
    localparam int DIR_RIGHT = 0;
    localparam int DIR_LEFT  = 1;
    localparam int DIR_DOWN  = 2;
    localparam int DIR_UP    = 3;

endpackage

`default_nettype wire

//--- rtl/board_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface board_ctrl_if (
    input logic clk_sys
);

    logic rot_control; // controls follow the rotated screen
    logic dip_flip;    // screen flip level from the OSD
    logic game_pause;  // toggled by key or button
    logic soft_rst;    // one-cycle pulse

    // settings decoder
    modport cfg (
        output rot_control,
        output dip_flip,
        input  game_pause
    );

    modport inputs (
        output game_pause,
        output soft_rst,
        input  rot_control
    );

    modport rst_gen (
        input soft_rst,
        input dip_flip
    );

endinterface

`default_nettype wire

//--- rtl/dip_decode.sv
`timescale 1ns/1ps
`default_nettype none

module dip_decode (
    input  logic                                 clk_sys,
    input  logic                                 rst,
    input  logic [board_cfg_pkg::STATUS_W-1:0]   status,
    input  logic [board_cfg_pkg::CORE_MOD_W-1:0] core_mod,
    board_ctrl_if.cfg                            ctrl,
    output logic [1:0]                           rotate,
    output logic                                 dip_test,
    output logic                                 dip_pause,
    output logic                                 enable_fm,
    output logic                                 enable_psg,
    output logic [1:0]                           dip_fxlevel
);
    import board_cfg_pkg::*;

    logic vertical;
    logic flip;

    assign vertical = core_mod[CORE_VERTICAL];
    assign flip     = status[ST_FLIP];

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            ctrl.rot_control <= 1'b0;
            ctrl.dip_flip    <= 1'b0;
            rotate           <= 2'b00;
            dip_test         <= 1'b1;  // low means test mode
            dip_pause        <= 1'b1;  // low means paused
            enable_fm        <= 1'b1;
            enable_psg       <= 1'b1;
            dip_fxlevel      <= 2'b00;
        end else begin
            // only a vertical game may rotate its controls
            ctrl.rot_control <= vertical & status[ST_ROT_CTRL];
            ctrl.dip_flip    <= flip;

            rotate[0] <= vertical & ~status[ST_NO_ROTATE];
            rotate[1] <= flip;

            dip_test    <= ~status[ST_TEST];
            dip_pause   <= ~ctrl.game_pause;
            enable_fm   <= ~status[ST_NO_FM];   // status bit set mutes the chip
            enable_psg  <= ~status[ST_NO_PSG];
            dip_fxlevel <= status[ST_FXLEVEL_LSB +: 2];
        end
    end

endmodule

`default_nettype wire

//--- rtl/game_reset_gen.sv
`timescale 1ns/1ps
`default_nettype none

module game_reset_gen (
    input  logic         clk_sys,
    input  logic         rst,
    input  logic         rst_req,
    input  logic         downloading,
    board_ctrl_if.rst_gen ctrl,
    output logic         game_rst
);
    import board_cfg_pkg::*;

    logic                 last_flip;
    logic                 flip_change;
    logic                 cause;
    logic [RST_CNT_W-1:0] hold_cnt;

    assign flip_change = last_flip != ctrl.dip_flip;

    // any of these restarts the hold time
    assign cause = rst | rst_req | downloading | ctrl.soft_rst | flip_change;

    always_ff @(posedge clk_sys) begin
        last_flip <= ctrl.dip_flip; // plain delay for edge compare
    end

    always_ff @(posedge clk_sys) begin
        if (cause) begin
            hold_cnt <= '0;
            game_rst <= 1'b1;
        end else if (hold_cnt != GAME_RST_HOLD) begin
            hold_cnt <= hold_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0; // counter parks at the limit
        end
    end

endmodule

`default_nettype wire

//--- rtl/player_inputs.sv
`timescale 1ns/1ps
`default_nettype none

module player_inputs #(
    parameter int BUTTONS = 2
) (
    input  logic                                clk_sys,
    input  logic                                rst,
    input  logic [player_io_pkg::BOARD_JOY_W-1:0] board_joystick1,
    input  logic [player_io_pkg::BOARD_JOY_W-1:0] board_joystick2,
    input  logic [player_io_pkg::BOARD_JOY_W-1:0] board_joystick3,
    input  logic [player_io_pkg::BOARD_JOY_W-1:0] board_joystick4,
    input  player_io_pkg::game_joy_t            key_joy1,
    input  player_io_pkg::game_joy_t            key_joy2,
    input  player_io_pkg::game_joy_t            key_joy3,
    input  player_io_pkg::player_bits_t         key_start,
    input  player_io_pkg::player_bits_t         key_coin,
    input  player_io_pkg::player_bits_t         key_gfx,
    input  logic                                key_reset,
    input  logic                                key_pause,
    input  logic                                key_service,
    board_ctrl_if.inputs                        ctrl,
    output player_io_pkg::game_joy_t            game_joystick1,
    output player_io_pkg::game_joy_t            game_joystick2,
    output player_io_pkg::game_joy_t            game_joystick3,
    output player_io_pkg::game_joy_t            game_joystick4,
    output player_io_pkg::player_bits_t         game_coin,
    output player_io_pkg::player_bits_t         game_start,
    output logic                                game_service,
    output logic [player_io_pkg::GFX_LAYERS-1:0] gfx_en
);
    import player_io_pkg::*;

    // coin, start and pause sit right above the fire buttons
    localparam int START_BIT = 6 + BUTTONS - 2;
    localparam int COIN_BIT  = 7 + BUTTONS - 2;
    localparam int PAUSE_BIT = 8 + BUTTONS - 2;

    logic [BOARD_JOY_W-1:0] joy_s [PLAYERS];
    game_joy_t              key_joy_s [PLAYERS-1]; // player 4 has no keys
    game_joy_t              merged [PLAYERS];
    game_joy_t              game_joy [PLAYERS];
    player_bits_t           key_start_s;
    player_bits_t           key_coin_s;
    player_bits_t           key_gfx_s;
    player_bits_t           last_gfx;
    player_bits_t           coin_raw;
    player_bits_t           start_raw;
    logic                   key_reset_s;
    logic                   key_pause_s;
    logic                   key_service_s;
    logic                   last_reset;
    logic                   last_pause;
    logic                   last_joypause;
    logic                   joy_pause;

    // quarter turn for vertical games, buttons untouched
    function automatic game_joy_t rotate_joy(input game_joy_t joy, input logic rot);
        game_joy_t rot_joy;
        rot_joy = joy;
        if (rot) begin
            rot_joy[DIR_RIGHT] = joy[DIR_DOWN];
            rot_joy[DIR_LEFT]  = joy[DIR_UP];
            rot_joy[DIR_DOWN]  = joy[DIR_LEFT];
            rot_joy[DIR_UP]    = joy[DIR_RIGHT];
        end
        return rot_joy;
    endfunction

    always_ff @(posedge clk_sys) begin
        joy_s[0]      <= board_joystick1;
        joy_s[1]      <= board_joystick2;
        joy_s[2]      <= board_joystick3;
        joy_s[3]      <= board_joystick4;
        key_joy_s[0]  <= key_joy1;
        key_joy_s[1]  <= key_joy2;
        key_joy_s[2]  <= key_joy3;
        key_start_s   <= key_start;
        key_coin_s    <= key_coin;
        key_gfx_s     <= key_gfx;
        key_reset_s   <= key_reset;
        key_pause_s   <= key_pause;
        key_service_s <= key_service;
    end

    always_comb begin
        for (int p = 0; p < PLAYERS; p++) begin
            merged[p]    = joy_s[p][GAME_JOY_W-1:0];
            coin_raw[p]  = joy_s[p][COIN_BIT];
            start_raw[p] = joy_s[p][START_BIT];
        end
        for (int p = 0; p < PLAYERS-1; p++) begin
            merged[p] = merged[p] | key_joy_s[p];
        end
    end

    assign joy_pause = joy_s[0][PAUSE_BIT] | joy_s[1][PAUSE_BIT];

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int p = 0; p < PLAYERS; p++) begin
                game_joy[p] <= {GAME_JOY_W{ACTIVE_LOW_INPUTS}};
            end
            game_coin       <= {PLAYERS{ACTIVE_LOW_INPUTS}};
            game_start      <= {PLAYERS{ACTIVE_LOW_INPUTS}};
            game_service    <= ACTIVE_LOW_INPUTS;
            ctrl.game_pause <= 1'b0;
            ctrl.soft_rst   <= 1'b0;
            gfx_en          <= '1;    // all layers visible
            last_reset      <= 1'b0;
            last_pause      <= 1'b0;
            last_joypause   <= 1'b0;
            last_gfx        <= '0;
        end else begin
            last_reset    <= key_reset_s;
            last_pause    <= key_pause_s;
            last_joypause <= joy_pause;
            last_gfx      <= key_gfx_s;

            for (int p = 0; p < PLAYERS; p++) begin
                game_joy[p] <= {GAME_JOY_W{ACTIVE_LOW_INPUTS}}
                             ^ rotate_joy(merged[p], ctrl.rot_control);
            end
            game_coin    <= {PLAYERS{ACTIVE_LOW_INPUTS}} ^ (coin_raw | key_coin_s);
            game_start   <= {PLAYERS{ACTIVE_LOW_INPUTS}} ^ (start_raw | key_start_s);
            game_service <= key_service_s ^ ACTIVE_LOW_INPUTS;

            ctrl.soft_rst <= key_reset_s & ~last_reset;

            // either source flips pause, holding does nothing
            if ((key_pause_s & ~last_pause) | (joy_pause & ~last_joypause)) begin
                ctrl.game_pause <= ~ctrl.game_pause;
            end
            for (int n = 0; n < GFX_LAYERS; n++) begin
                if (key_gfx_s[n] & ~last_gfx[n]) begin
                    gfx_en[n] <= ~gfx_en[n];
                end
            end
        end
    end

    assign game_joystick1 = game_joy[0];
    assign game_joystick2 = game_joy[1];
    assign game_joystick3 = game_joy[2];
    assign game_joystick4 = game_joy[3];

endmodule

`default_nettype wire

//--- rtl/board_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_top #(
    parameter int BUTTONS = 2
) (
    input  logic                                  clk_sys,
    input  logic                                  rst,
    input  logic                                  rst_req,
    input  logic                                  downloading,
    input  logic [board_cfg_pkg::STATUS_W-1:0]    status,
    input  logic [board_cfg_pkg::CORE_MOD_W-1:0]  core_mod,
    input  logic [player_io_pkg::BOARD_JOY_W-1:0] board_joystick1,
    input  logic [player_io_pkg::BOARD_JOY_W-1:0] board_joystick2,
    input  logic [player_io_pkg::BOARD_JOY_W-1:0] board_joystick3,
    input  logic [player_io_pkg::BOARD_JOY_W-1:0] board_joystick4,
    input  player_io_pkg::game_joy_t              key_joy1,
    input  player_io_pkg::game_joy_t              key_joy2,
    input  player_io_pkg::game_joy_t              key_joy3,
    input  player_io_pkg::player_bits_t           key_start,
    input  player_io_pkg::player_bits_t           key_coin,
    input  player_io_pkg::player_bits_t           key_gfx,
    input  logic                                  key_reset,
    input  logic                                  key_pause,
    input  logic                                  key_service,
    output logic                                  game_rst,
    output logic [1:0]                            rotate,
    output logic                                  dip_test,
    output logic                                  dip_pause,
    output logic                                  enable_fm,
    output logic                                  enable_psg,
    output logic [1:0]                            dip_fxlevel,
    output player_io_pkg::game_joy_t              game_joystick1,
    output player_io_pkg::game_joy_t              game_joystick2,
    output player_io_pkg::game_joy_t              game_joystick3,
    output player_io_pkg::game_joy_t              game_joystick4,
    output player_io_pkg::player_bits_t           game_coin,
    output player_io_pkg::player_bits_t           game_start,
    output logic                                  game_service,
    output logic [player_io_pkg::GFX_LAYERS-1:0]  gfx_en
);

    board_ctrl_if i_ctrl (
        .clk_sys (clk_sys)
    );

    dip_decode i_dip_decode (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .status      (status),
        .core_mod    (core_mod),
        .ctrl        (i_ctrl.cfg),
        .rotate      (rotate),
        .dip_test    (dip_test),
        .dip_pause   (dip_pause),
        .enable_fm   (enable_fm),
        .enable_psg  (enable_psg),
        .dip_fxlevel (dip_fxlevel)
    );

    game_reset_gen i_game_reset_gen (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .rst_req     (rst_req),
        .downloading (downloading),
        .ctrl        (i_ctrl.rst_gen),
        .game_rst    (game_rst)
    );

    player_inputs #(
        .BUTTONS (BUTTONS)
    ) i_player_inputs (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .board_joystick3 (board_joystick3),
        .board_joystick4 (board_joystick4),
        .key_joy1        (key_joy1),
        .key_joy2        (key_joy2),
        .key_joy3        (key_joy3),
        .key_start       (key_start),
        .key_coin        (key_coin),
        .key_gfx         (key_gfx),
        .key_reset       (key_reset),
        .key_pause       (key_pause),
        .key_service     (key_service),
        .ctrl            (i_ctrl.inputs),
        .game_joystick1  (game_joystick1),
        .game_joystick2  (game_joystick2),
        .game_joystick3  (game_joystick3),
        .game_joystick4  (game_joystick4),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .game_service    (game_service),
        .gfx_en          (gfx_en)
    );

endmodule

`default_nettype wire

//--- testbench/tb_board_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_top;
    import board_cfg_pkg::*;
    import player_io_pkg::*;

    localparam int BUTTONS     = 2;
    localparam int START_POS   = 6 + BUTTONS - 2;
    localparam int COIN_POS    = 7 + BUTTONS - 2;
    localparam int NUM_ROWS    = 15;
    localparam int RESET_TESTS = 3;
    localparam int WATCHDOG_CYCLES = 16 + NUM_ROWS * 10
                                   + RESET_TESTS * (2 * GAME_RST_HOLD + 20) + 600;

    // fill only bits that no output depends on
    localparam logic [15:0] JOY_FILL    = 16'hFC00;
    localparam logic [31:0] STATUS_FILL = 32'hFFFF_FC00;
    localparam logic [6:0]  CORE_FILL   = 7'h7E;

    typedef struct {
        string            name;
        logic [3:0][15:0] joy;       // board joysticks, player 1 lowest
        logic [2:0][9:0]  kjoy;      // key words, player 1 lowest
        logic [3:0]       kstart;
        logic [3:0]       kcoin;
        logic [3:0]       kgfx;
        logic             kpause;
        logic             kservice;
        logic [31:0]      status;
        logic [6:0]       core_mod;
        logic             exp_pause; // dip_pause level, low when paused
        logic [3:0]       exp_gfx;
    } row_t;

    logic clk_sys = 1'b0;
    logic rst;
    logic rst_req;
    logic downloading;
    logic [31:0] status;
    logic [6:0] core_mod;
    logic [15:0] board_joystick1;
    logic [15:0] board_joystick2;
    logic [15:0] board_joystick3;
    logic [15:0] board_joystick4;
    game_joy_t key_joy1;
    game_joy_t key_joy2;
    game_joy_t key_joy3;
    player_bits_t key_start;
    player_bits_t key_coin;
    player_bits_t key_gfx;
    logic key_reset;
    logic key_pause;
    logic key_service;
    logic game_rst;
    logic [1:0] rotate;
    logic dip_test;
    logic dip_pause;
    logic enable_fm;
    logic enable_psg;
    logic [1:0] dip_fxlevel;
    game_joy_t game_joystick1;
    game_joy_t game_joystick2;
    game_joy_t game_joystick3;
    game_joy_t game_joystick4;
    player_bits_t game_coin;
    player_bits_t game_start;
    logic game_service;
    logic [3:0] gfx_en;

    row_t rows [NUM_ROWS];
    int   seed = 6809;
    int   errors = 0;
    int   tests_run = 0;
    int   tests_failed = 0;

    board_top #(
        .BUTTONS (BUTTONS)
    ) i_board_top (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .rst_req         (rst_req),
        .downloading     (downloading),
        .status          (status),
        .core_mod        (core_mod),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .board_joystick3 (board_joystick3),
        .board_joystick4 (board_joystick4),
        .key_joy1        (key_joy1),
        .key_joy2        (key_joy2),
        .key_joy3        (key_joy3),
        .key_start       (key_start),
        .key_coin        (key_coin),
        .key_gfx         (key_gfx),
        .key_reset       (key_reset),
        .key_pause       (key_pause),
        .key_service     (key_service),
        .game_rst        (game_rst),
        .rotate          (rotate),
        .dip_test        (dip_test),
        .dip_pause       (dip_pause),
        .enable_fm       (enable_fm),
        .enable_psg      (enable_psg),
        .dip_fxlevel     (dip_fxlevel),
        .game_joystick1  (game_joystick1),
        .game_joystick2  (game_joystick2),
        .game_joystick3  (game_joystick3),
        .game_joystick4  (game_joystick4),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .game_service    (game_service),
        .gfx_en          (gfx_en)
    );

    always #5 clk_sys = ~clk_sys;

    // merge with keys, quarter turn if asked, then low-true
    function automatic logic [9:0] expect_joy(input logic [15:0] board, input logic [9:0] keys,
                                              input logic rot);
        int         src [4];
        logic [9:0] merged;
        logic [9:0] turned;
        src    = '{DIR_DOWN, DIR_UP, DIR_LEFT, DIR_RIGHT}; // feeds right, left, down, up
        merged = board[9:0] | keys;
        turned = merged;
        if (rot) begin
            for (int d = 0; d < 4; d++) begin
                turned[d] = merged[src[d]];
            end
        end
        return ~turned;
    endfunction

    function automatic logic [3:0] expect_player_bits(input logic [3:0][15:0] joy,
                                                      input logic [3:0] keys, input int pos);
        logic [3:0] bits;
        for (int p = 0; p < 4; p++) begin
            bits[p] = joy[p][pos] | keys[p];
        end
        return ~bits;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s expected %h actual %h", test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string test, input int start_err);
        tests_run++;
        if (errors == start_err) begin
            $display("test %-18s ok", test);
        end else begin
            tests_failed++;
            $display("test %-18s %0d mismatches", test, errors - start_err);
        end
    endtask

    task automatic load_table();
        rows[0]  = '{"reset_state", 64'h0, 30'h0, 4'h0, 4'h0, 4'h0, 1'b0, 1'b0,
                     32'h0, 7'h0, 1'b1, 4'hF};
        rows[1]  = '{"merge_invert", {16'h02F0, 16'h0103, 16'h00C0, 16'h0005},
                     {10'h200, 10'h000, 10'h00A}, 4'b0100, 4'b1000, 4'h0, 1'b0, 1'b1,
                     32'h0000_0240, 7'h0, 1'b1, 4'hF};
        rows[2]  = '{"rotate_vertical", {16'h0008, 16'h0004, 16'h0002, 16'h0001},
                     {10'h000, 10'h001, 10'h000}, 4'h0, 4'h0, 4'h0, 1'b0, 1'b0,
                     32'h4, 7'h01, 1'b1, 4'hF};
        rows[3]  = '{"rotate_fixed", {16'h0031, 16'h0042, 16'h0014, 16'h0028},
                     30'h0, 4'h0, 4'h0, 4'h0, 1'b0, 1'b0, 32'hC, 7'h01, 1'b1, 4'hF};
        rows[4]  = '{"horizontal_core", {16'h0008, 16'h0004, 16'h0002, 16'h0001},
                     30'h0, 4'h0, 4'h0, 4'h0, 1'b0, 1'b0, 32'h4, 7'h00, 1'b1, 4'hF};
        rows[5]  = '{"dip_flags", 64'h0, 30'h0, 4'h0, 4'h0, 4'h0, 1'b0, 1'b0,
                     32'h0000_01B0, 7'h0, 1'b1, 4'hF};
        rows[6]  = '{"key_pause_rise", 64'h0, 30'h0, 4'h0, 4'h0, 4'h0, 1'b1, 1'b0,
                     32'h0, 7'h0, 1'b0, 4'hF};
        rows[7]  = '{"key_pause_hold", 64'h0, 30'h0, 4'h0, 4'h0, 4'h0, 1'b1, 1'b0,
                     32'h0, 7'h0, 1'b0, 4'hF};
        rows[8]  = '{"key_pause_release", 64'h0, 30'h0, 4'h0, 4'h0, 4'h0, 1'b0, 1'b0,
                     32'h0, 7'h0, 1'b0, 4'hF};
        rows[9]  = '{"joy_pause_rise", {16'h0, 16'h0, 16'h0100, 16'h0}, 30'h0, 4'h0, 4'h0,
                     4'h0, 1'b0, 1'b0, 32'h0, 7'h0, 1'b1, 4'hF};
        rows[10] = '{"joy_pause_hold", {16'h0, 16'h0, 16'h0100, 16'h0}, 30'h0, 4'h0, 4'h0,
                     4'h0, 1'b0, 1'b0, 32'h0, 7'h0, 1'b1, 4'hF};
        rows[11] = '{"gfx_layer0", 64'h0, 30'h0, 4'h0, 4'h0, 4'b0001, 1'b0, 1'b0,
                     32'h0, 7'h0, 1'b1, 4'hE};
        rows[12] = '{"gfx_layer2", 64'h0, 30'h0, 4'h0, 4'h0, 4'b0101, 1'b0, 1'b0,
                     32'h0, 7'h0, 1'b1, 4'hA};
        rows[13] = '{"gfx_release", 64'h0, 30'h0, 4'h0, 4'h0, 4'b0000, 1'b0, 1'b0,
                     32'h0, 7'h0, 1'b1, 4'hA};
        rows[14] = '{"gfx_layer0_again", 64'h0, 30'h0, 4'h0, 4'h0, 4'b0001, 1'b0, 1'b0,
                     32'h0, 7'h0, 1'b1, 4'hB};
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] fill;
        fill = $random(seed);
        board_joystick1 = r.joy[0] | (fill[15:0] & JOY_FILL);
        board_joystick2 = r.joy[1] | (fill[31:16] & JOY_FILL);
        fill = $random(seed);
        board_joystick3 = r.joy[2] | (fill[15:0] & JOY_FILL);
        board_joystick4 = r.joy[3] | (fill[31:16] & JOY_FILL);
        fill = $random(seed);
        status   = r.status | (fill & STATUS_FILL);
        core_mod = r.core_mod | (fill[6:0] & CORE_FILL);
        key_joy1    = r.kjoy[0];
        key_joy2    = r.kjoy[1];
        key_joy3    = r.kjoy[2];
        key_start   = r.kstart;
        key_coin    = r.kcoin;
        key_gfx     = r.kgfx;
        key_pause   = r.kpause;
        key_service = r.kservice;
    endtask

    // cause 0 is rst_req, 1 is key_reset, anything else flips the screen
    task automatic reset_test(input string test, input int cause, input int exp_latency);
        int start_err;
        int latency;
        int held;
        start_err = errors;
        held = 0;
        while (game_rst && held <= GAME_RST_HOLD + 2) begin // earlier reset runs out
            @(posedge clk_sys);
            #1;
            held++;
        end
        if (game_rst) begin
            $display("%s: game_rst stayed high before the test could start", test);
            errors++;
        end
        @(posedge clk_sys);
        #1;
        case (cause)
            0: rst_req = 1'b1;
            1: key_reset = 1'b1;
            default: status[ST_FLIP] = ~status[ST_FLIP];
        endcase
        latency = 0;
        while (!game_rst && latency < 8) begin
            @(posedge clk_sys);
            #1;
            rst_req = 1'b0;  // one cycle only
            latency++;
        end
        check_value(test, "latency", 32'(exp_latency), 32'(latency));
        held = 0;
        while (game_rst && held <= GAME_RST_HOLD + 2) begin
            @(posedge clk_sys);
            #1;
            if (game_rst) begin
                held++;
            end
        end
        check_value(test, "hold_cycles", 32'(GAME_RST_HOLD), 32'(held));
        key_reset = 1'b0;
        report_test(test, start_err);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin
        row_t r;
        int   start_err;
        logic vertical;
        logic rot_on;
        rst             = 1'b1;
        rst_req         = 1'b0;
        downloading     = 1'b0;
        status          = '0;
        core_mod        = '0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        board_joystick3 = '0;
        board_joystick4 = '0;
        key_joy1        = '0;
        key_joy2        = '0;
        key_joy3        = '0;
        key_start       = '0;
        key_coin        = '0;
        key_gfx         = '0;
        key_reset       = 1'b0;
        key_pause       = 1'b0;
        key_service     = 1'b0;
        load_table();
        repeat (16) @(posedge clk_sys);
        #1;
        rst = 1'b0;

        for (int i = 0; i < NUM_ROWS; i++) begin
            r = rows[i];
            start_err = errors;
            apply_row(r);
            repeat (3) @(posedge clk_sys);
            @(negedge clk_sys);
            vertical = r.core_mod[CORE_VERTICAL];
            rot_on   = vertical & r.status[ST_ROT_CTRL];
            check_value(r.name, "game_joystick1", 32'(expect_joy(r.joy[0], r.kjoy[0], rot_on)),
                        32'(game_joystick1));
            check_value(r.name, "game_joystick2", 32'(expect_joy(r.joy[1], r.kjoy[1], rot_on)),
                        32'(game_joystick2));
            check_value(r.name, "game_joystick3", 32'(expect_joy(r.joy[2], r.kjoy[2], rot_on)),
                        32'(game_joystick3));
            check_value(r.name, "game_joystick4", 32'(expect_joy(r.joy[3], 10'h0, rot_on)),
                        32'(game_joystick4));
            check_value(r.name, "game_coin", 32'(expect_player_bits(r.joy, r.kcoin, COIN_POS)),
                        32'(game_coin));
            check_value(r.name, "game_start",
                        32'(expect_player_bits(r.joy, r.kstart, START_POS)), 32'(game_start));
            check_value(r.name, "game_service", 32'(!r.kservice), 32'(game_service));
            check_value(r.name, "rotate",
                        32'({r.status[ST_FLIP], vertical & ~r.status[ST_NO_ROTATE]}),
                        32'(rotate));
            check_value(r.name, "dip_test", 32'(!r.status[ST_TEST]), 32'(dip_test));
            check_value(r.name, "enable_fm", 32'(!r.status[ST_NO_FM]), 32'(enable_fm));
            check_value(r.name, "enable_psg", 32'(!r.status[ST_NO_PSG]), 32'(enable_psg));
            check_value(r.name, "dip_fxlevel", 32'(r.status[ST_FXLEVEL_LSB +: 2]),
                        32'(dip_fxlevel));
            check_value(r.name, "dip_pause", 32'(r.exp_pause), 32'(dip_pause));
            check_value(r.name, "gfx_en", 32'(r.exp_gfx), 32'(gfx_en));
            report_test(r.name, start_err);
            @(posedge clk_sys);
            #1;
        end

        reset_test("reset_request", 0, 1); // sampled at the next edge
        reset_test("key_reset", 1, 3);     // sync, pulse, then sampled
        reset_test("flip_change", 2, 2);   // decode register, then sampled

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/board_cfg_pkg.sv
rtl/player_io_pkg.sv
rtl/board_ctrl_if.sv
rtl/dip_decode.sv
rtl/game_reset_gen.sv
rtl/player_inputs.sv
rtl/board_top.sv
testbench/tb_board_top.sv

//--- run_sim.sh
#!/bin/sh
# build the board control testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_board_top -f vlog.f -o sim_board || exit 1
result=$(./obj_dir/sim_board)
echo "$result"
echo "$result" | grep -qx "Regression passed" && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }
